//--- design/acqSequencer.sv
`timescale 1ns/1ns

module acqSequencer (
    input  logic        clk,
    input  logic        combin_res,
    input  logic        wrEn,
    sampleTagIf.source  tag,
    output logic        finePass
);

    logic [$clog2(histPkg::SAMPLE_NUM)-1:0] sampleCnt;
    logic [histPkg::PIXEL_W-1:0]            pixelCnt;
    logic [$clog2(histPkg::ACQ_NUM)-1:0]    acqCnt;

    logic sampleWrap;
    logic pixelWrap;
    logic acqWrap;

    // wrap points of the three nested counters
    assign sampleWrap = (sampleCnt == histPkg::SAMPLE_NUM - 1);
    assign pixelWrap  = (pixelCnt == histPkg::PIXEL_NUM - 1);
    assign acqWrap    = (acqCnt == histPkg::ACQ_NUM - 1);

    // tag describes the sample strobed this very cycle
    assign tag.valid = wrEn;
    assign tag.pixel = pixelCnt;
    assign tag.fine  = finePass;
    assign tag.last  = wrEn && sampleWrap && pixelWrap && acqWrap;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt  <= '0;
            acqCnt    <= '0;
            finePass  <= 1'b0;
        end else if (wrEn) begin
            if (!sampleWrap) begin
                sampleCnt <= sampleCnt + 1'b1;
            end else begin
                sampleCnt <= '0;
                if (!pixelWrap) begin
                    pixelCnt <= pixelCnt + 1'b1;
                end else begin
                    pixelCnt <= '0;
                    if (!acqWrap) begin
                        acqCnt <= acqCnt + 1'b1;
                    end else begin
                        acqCnt   <= '0;
                        finePass <= ~finePass; // pass complete, switch mode
                    end
                end
            end
        end
    end

endmodule

//--- design/binMapper.sv
`timescale 1ns/1ns

module binMapper (
    input  logic                                          clk,
    input  logic                                          combin_res,
    input  logic [histPkg::STAMP_W-1:0]                   stamp,
    sampleTagIf.sink                                      tag,
    input  logic [histPkg::PIXEL_NUM*histPkg::BIN_W-1:0]  peakBins,
    input  logic                                          passDone,
    input  logic                                          donePass,
    output logic [histPkg::BIN_W-1:0]                     binIdx,
    output logic                                          binHit,
    output logic [histPkg::PIXEL_NUM*histPkg::STAMP_W-1:0] peakResults,
    output logic                                          resultValid
);

    histPkg::stampWord_u         word;
    logic [histPkg::STAMP_W-1:0] windowLow [histPkg::PIXEL_NUM];
    logic [histPkg::STAMP_W-1:0] nextLow   [histPkg::PIXEL_NUM];
    logic [histPkg::STAMP_W-1:0] curLow;
    logic [histPkg::STAMP_W-1:0] offset;
    logic                        inWindow;
    logic [histPkg::STAMP_W-1:0] centre;

    assign word = stamp;

    // fine view relative to the pixel's window
    assign curLow   = windowLow[tag.pixel];
    assign offset   = word.raw - curLow;
    assign inWindow = (word.raw >= curLow) && (offset <= histPkg::BIN_NUM - 1);

    // new windows from the coarse peaks
    always_comb begin
        centre = '0;
        for (int p = 0; p < histPkg::PIXEL_NUM; p++) begin
            centre = {peakBins[p*histPkg::BIN_W +: histPkg::BIN_W],
                      {(histPkg::STAMP_W - histPkg::BIN_W){1'b0}}};
            if (centre <= histPkg::HALF_WIN) begin
                nextLow[p] = '0; // clamp at bottom edge
            end else if (int'(centre) - histPkg::HALF_WIN > histPkg::WIN_LOW_MAX) begin
                nextLow[p] = histPkg::WIN_LOW_MAX[histPkg::STAMP_W-1:0];
            end else begin
                nextLow[p] = centre - histPkg::HALF_WIN[histPkg::STAMP_W-1:0];
            end
        end
    end

    // bin index from the coarse field or the window offset
    always_ff @(posedge clk) begin
        if (tag.fine) begin
            binIdx <= offset[histPkg::BIN_W-1:0];
        end else begin
            binIdx <= word.coarse.bin;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binHit <= 1'b0;
        end else begin
            binHit <= tag.valid && (!tag.fine || inWindow); // out-of-window fine samples dropped
        end
    end

    // windows follow each coarse pass
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < histPkg::PIXEL_NUM; p++) begin
                windowLow[p] <= '0;
            end
        end else if (passDone && !donePass) begin
            for (int p = 0; p < histPkg::PIXEL_NUM; p++) begin
                windowLow[p] <= nextLow[p];
            end
        end
    end

    // final result is window edge plus fine peak
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peakResults <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= passDone && donePass;
            if (passDone && donePass) begin
                for (int p = 0; p < histPkg::PIXEL_NUM; p++) begin
                    peakResults[p*histPkg::STAMP_W +: histPkg::STAMP_W] <= windowLow[p] +
                        {{(histPkg::STAMP_W - histPkg::BIN_W){1'b0}},
                         peakBins[p*histPkg::BIN_W +: histPkg::BIN_W]};
                end
            end
        end
    end

endmodule

//--- design/histPeakTracker.sv
`timescale 1ns/1ns

module histPeakTracker (
    input  logic                                          clk,
    input  logic                                          combin_res,
    sampleTagIf.sink                                      tag,
    input  logic [histPkg::BIN_W-1:0]                     binIdx,
    input  logic                                          binHit,
    output logic [histPkg::PIXEL_NUM*histPkg::BIN_W-1:0]  peakBins,
    output logic                                          passDone,
    output logic                                          donePass
);

    localparam int MEM_DEPTH = histPkg::PIXEL_NUM * histPkg::BIN_NUM;

    // count memory, lazily cleared through binValid
    logic [histPkg::COUNT_W-1:0] countMem [MEM_DEPTH];
    logic [MEM_DEPTH-1:0]        binValid;

    // stage 1, aligned with binIdx and binHit
    logic [histPkg::PIXEL_W-1:0] pixel1;
    logic                        last1;
    logic                        fine1;

    // stage 2, new count
    logic [histPkg::COUNT_W-1:0] count2;
    logic [histPkg::BIN_W-1:0]   bin2;
    logic [histPkg::PIXEL_W-1:0] pixel2;
    logic                        hit2;
    logic                        last2;
    logic                        fine2;

    // stage 3, running max
    logic [histPkg::COUNT_W-1:0] peakCount [histPkg::PIXEL_NUM];
    logic [histPkg::BIN_W-1:0]   peakBin   [histPkg::PIXEL_NUM];
    logic                        last3;
    logic                        fine3;

    logic [histPkg::PIXEL_W+histPkg::BIN_W-1:0] addr;
    logic [histPkg::COUNT_W-1:0]                newCount;

    assign addr     = {pixel1, binIdx};
    assign newCount = binValid[addr] ? countMem[addr] + 1'b1 : histPkg::COUNT_W'(1);

    // pixel only changes with a strobe
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            pixel1 <= '0;
            last1  <= 1'b0;
            fine1  <= 1'b0;
        end else begin
            if (tag.valid) begin
                pixel1 <= tag.pixel;
                fine1  <= tag.fine;
            end
            last1 <= tag.last;
        end
    end

    always_ff @(posedge clk) begin
        if (binHit) begin
            countMem[addr] <= newCount; // read-modify-write in one cycle
        end
        count2 <= newCount;
        bin2   <= binIdx;
        pixel2 <= pixel1;
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
            hit2     <= 1'b0;
            last2    <= 1'b0;
            fine2    <= 1'b0;
        end else begin
            hit2  <= binHit;
            last2 <= last1;
            fine2 <= fine1;
            if (last3) begin
                binValid <= '0; // lazy clear of the whole memory
            end else if (binHit) begin
                binValid[addr] <= 1'b1;
            end
        end
    end

    // strictly greater, so the first bin to reach a count keeps it
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < histPkg::PIXEL_NUM; p++) begin
                peakCount[p] <= '0;
                peakBin[p]   <= '0;
            end
            last3 <= 1'b0;
            fine3 <= 1'b0;
        end else begin
            last3 <= last2;
            fine3 <= fine2;
            if (last3) begin
                for (int p = 0; p < histPkg::PIXEL_NUM; p++) begin
                    peakCount[p] <= '0;
                    peakBin[p]   <= '0;
                end
            end else if (hit2 && (count2 > peakCount[pixel2])) begin
                peakCount[pixel2] <= count2;
                peakBin[pixel2]   <= bin2;
            end
        end
    end

    // snapshot of the peaks, taken as they clear
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peakBins <= '0;
            passDone <= 1'b0;
            donePass <= 1'b0;
        end else begin
            passDone <= last3;
            if (last3) begin
                donePass <= fine3;
                for (int p = 0; p < histPkg::PIXEL_NUM; p++) begin
                    peakBins[p*histPkg::BIN_W +: histPkg::BIN_W] <= peakBin[p];
                end
            end
        end
    end

endmodule

//--- design/histPkg.sv
package histPkg;

    // timestamp and bin sizes
    localparam int STAMP_W = 8;       // one timestamp word
    localparam int BIN_W   = 4;       // bin index, same in both passes
    localparam int BIN_NUM = 16;      // bins per pixel histogram

    // array and acquisition shape
    localparam int PIXEL_NUM  = 4;
    localparam int PIXEL_W    = 2;
    localparam int SAMPLE_NUM = 4;    // consecutive samples per pixel
    localparam int ACQ_NUM    = 4;    // acquisitions per pass

    // a bin can collect SAMPLE_NUM * ACQ_NUM hits in one pass
    localparam int COUNT_W = 5;

    // fine window geometry
    localparam int HALF_WIN    = 8;
    localparam int WIN_LOW_MAX = 240; // keeps the 16-wide window below 256

    // one timestamp word, read two ways:
    // raw is the plain value for the fine pass,
    // coarse splits it into bin and fraction for the coarse pass
    typedef union packed {
        logic [STAMP_W-1:0] raw;
        struct packed {
            logic [BIN_W-1:0]         bin;  // upper bits pick the coarse bin
            logic [STAMP_W-BIN_W-1:0] frac; // ignored by the coarse pass
        } coarse;
    } stampWord_u;

endpackage

//--- design/sampleTagIf.sv
`timescale 1ns/1ns

interface sampleTagIf;

    logic                        valid; // sample strobed this cycle
    logic [histPkg::PIXEL_W-1:0] pixel; // pixel the sample belongs to
    logic                        fine;  // 1 in the fine pass
    logic                        last;  // final sample of the pass

    // sequencer side
    modport source (
        output valid,
        output pixel,
        output fine,
        output last
    );

    // mapper and tracker side
    modport sink (
        input valid,
        input pixel,
        input fine,
        input last
    );

endinterface

//--- design/timingHistogrammer.sv
`timescale 1ns/1ns

module timingHistogrammer (
    input  logic                                          clk,
    input  logic                                          combin_res,
    input  logic                                          wrEn,
    input  logic [histPkg::STAMP_W-1:0]                   stamp,
    output logic [histPkg::PIXEL_NUM*histPkg::STAMP_W-1:0] peakResults,
    output logic                                          resultValid,
    output logic                                          finePass
);

    logic [histPkg::BIN_W-1:0]                    binIdx;
    logic                                         binHit;
    logic [histPkg::PIXEL_NUM*histPkg::BIN_W-1:0] peakBins;
    logic                                         passDone;
    logic                                         donePass; // 1 when the fine pass ended

    sampleTagIf tagBus ();

    acqSequencer u_acqSequencer (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .tag        (tagBus.source),
        .finePass   (finePass)
    );

    binMapper u_binMapper (
        .clk         (clk),
        .combin_res  (combin_res),
        .stamp       (stamp),
        .tag         (tagBus.sink),
        .peakBins    (peakBins),
        .passDone    (passDone),
        .donePass    (donePass),
        .binIdx      (binIdx),
        .binHit      (binHit),
        .peakResults (peakResults),
        .resultValid (resultValid)
    );

    histPeakTracker u_histPeakTracker (
        .clk        (clk),
        .combin_res (combin_res),
        .tag        (tagBus.sink),
        .binIdx     (binIdx),
        .binHit     (binHit),
        .peakBins   (peakBins),
        .passDone   (passDone),
        .donePass   (donePass)
    );

endmodule

//--- dv/clockGen.sv
`timescale 1ns/1ns

module clockGen (
    output logic clk,
    output logic combin_res
);

    localparam int HALF_PERIOD  = 50; // 100 ns clock
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release a little after the edge, like the other inputs
    initial begin
        combin_res = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 combin_res = 1'b1;
    end

endmodule

//--- dv/timingHistogrammerTb.sv
`timescale 1ns/1ns

module timingHistogrammerTb;

    localparam int PASS_LEN    = histPkg::SAMPLE_NUM * histPkg::PIXEL_NUM * histPkg::ACQ_NUM;
    localparam int RES_W       = histPkg::PIXEL_NUM * histPkg::STAMP_W;
    localparam int COARSE_SPAN = 1 << (histPkg::STAMP_W - histPkg::BIN_W); // stamps per coarse bin
    localparam int IDLE_GAP    = 6; // idle cycles between passes
    localparam int MAX_GAP     = 3; // random strobe gap in the repeated cycles
    localparam int FINE_PASSES = 7;
    // reset, eight back-to-back passes, six passes with gaps
    localparam int STIM_CYCLES = 16 + 8 * (PASS_LEN + IDLE_GAP + 1)
                               + 6 * (PASS_LEN * (MAX_GAP + 1) + IDLE_GAP + 1);
    localparam int CYCLE_LIMIT = STIM_CYCLES + 200;

    typedef logic [histPkg::STAMP_W-1:0] stampList_t [PASS_LEN];

    logic                        clk;
    logic                        combin_res;
    logic                        wrEn;
    logic [histPkg::STAMP_W-1:0] stamp;
    logic [RES_W-1:0]            peakResults;
    logic                        resultValid;
    logic                        finePass;

    stampList_t       coarseStamps;
    stampList_t       fineStamps;
    logic [RES_W-1:0] expQueue [$];  // one entry per fine pass in flight
    string            nameQueue [$];
    logic [RES_W-1:0] expVal;
    string            expName;
    string            testName;
    int               resultCount = 0;
    int               fineEnded = 0;   // fine passes whose last strobe went out
    int               cycleCount = 0;

    clockGen u_clockGen (
        .clk        (clk),
        .combin_res (combin_res)
    );

    timingHistogrammer u_timingHistogrammer (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .stamp       (stamp),
        .peakResults (peakResults),
        .resultValid (resultValid),
        .finePass    (finePass)
    );

    task automatic failAndStop();
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    // arrival order is acquisition, then pixel, then sample
    function automatic int pixelOf(input int i);
        return (i / histPkg::SAMPLE_NUM) % histPkg::PIXEL_NUM;
    endfunction

    function automatic int sampleOf(input int i);
        return i % histPkg::SAMPLE_NUM;
    endfunction

    function automatic int acqOf(input int i);
        return i / (histPkg::SAMPLE_NUM * histPkg::PIXEL_NUM);
    endfunction

    function automatic logic [histPkg::STAMP_W-1:0] jitterAround(input int centre, input int spread);
        return histPkg::STAMP_W'(centre + int'($urandom_range(2 * spread, 0)) - spread);
    endfunction

    // replays one coarse pass and one fine pass through the binning rules
    function automatic logic [RES_W-1:0] expectResults(input stampList_t coarseList,
                                                       input stampList_t fineList);
        int                  counts   [histPkg::PIXEL_NUM][histPkg::BIN_NUM];
        int                  maxCount [histPkg::PIXEL_NUM];
        int                  maxBin   [histPkg::PIXEL_NUM];
        int                  winLow   [histPkg::PIXEL_NUM];
        int                  pix;
        int                  bin;
        int                  centre;
        logic                hit;
        histPkg::stampWord_u word;
        logic [RES_W-1:0]    res;

        res = '0;
        for (int p = 0; p < histPkg::PIXEL_NUM; p++) winLow[p] = 0;
        for (int pass = 0; pass < 2; pass++) begin
            for (int p = 0; p < histPkg::PIXEL_NUM; p++) begin
                maxCount[p] = 0;
                maxBin[p]   = 0;
                for (int b = 0; b < histPkg::BIN_NUM; b++) counts[p][b] = 0;
            end
            for (int i = 0; i < PASS_LEN; i++) begin
                pix = pixelOf(i);
                if (pass == 0) begin
                    word.raw = coarseList[i];
                    bin      = int'(word.coarse.bin);
                    hit      = 1'b1;
                end else begin
                    word.raw = fineList[i];
                    bin      = int'(word.raw) - winLow[pix];
                    hit      = (bin >= 0) && (bin < histPkg::BIN_NUM); // drop outside the window
                end
                if (hit) begin
                    counts[pix][bin] = counts[pix][bin] + 1;
                    if (counts[pix][bin] > maxCount[pix]) begin // first to reach keeps it
                        maxCount[pix] = counts[pix][bin];
                        maxBin[pix]   = bin;
                    end
                end
            end
            for (int p = 0; p < histPkg::PIXEL_NUM; p++) begin
                if (pass == 0) begin
                    centre = maxBin[p] * COARSE_SPAN;
                    if (centre <= histPkg::HALF_WIN) winLow[p] = 0;
                    else if (centre - histPkg::HALF_WIN > histPkg::WIN_LOW_MAX)
                        winLow[p] = histPkg::WIN_LOW_MAX;
                    else winLow[p] = centre - histPkg::HALF_WIN;
                end else begin
                    res[p*histPkg::STAMP_W +: histPkg::STAMP_W] =
                        histPkg::STAMP_W'(winLow[p] + maxBin[p]);
                end
            end
        end
        return res;
    endfunction

    task automatic runPass(input stampList_t list, input logic fineFlag, input int maxGap);
        int gap;
        @(negedge clk);
        assert (finePass == fineFlag) else begin
            $display("error %s: finePass expected %0b actual %0b", testName, fineFlag, finePass);
            failAndStop();
        end
        for (int i = 0; i < PASS_LEN; i++) begin
            gap = (maxGap > 0) ? int'($urandom_range(maxGap, 0)) : 0;
            repeat (gap) begin
                @(posedge clk);
                #10 wrEn = 1'b0;
            end
            @(posedge clk);
            #10;
            wrEn  = 1'b1;
            stamp = list[i];
        end
        if (fineFlag) begin
            fineEnded = fineEnded + 1;
        end
        repeat (IDLE_GAP) begin // lets the windows settle
            @(posedge clk);
            #10 wrEn = 1'b0;
        end
    endtask

    task automatic runCycle(input int maxGap);
        logic [RES_W-1:0] expected;
        expected = expectResults(coarseStamps, fineStamps);
        runPass(coarseStamps, 1'b0, maxGap);
        expQueue.push_back(expected);
        nameQueue.push_back(testName);
        runPass(fineStamps, 1'b1, maxGap);
    endtask

    // distinct cluster per pixel in the middle of the range
    task automatic fillClustered();
        int centre [histPkg::PIXEL_NUM];
        for (int p = 0; p < histPkg::PIXEL_NUM; p++)
            centre[p] = 48 + 40 * p + int'($urandom_range(16, 0));
        for (int i = 0; i < PASS_LEN; i++) begin
            coarseStamps[i] = jitterAround(centre[pixelOf(i)], 3);
            fineStamps[i]   = jitterAround(centre[pixelOf(i)], 3);
        end
    endtask

    // pixel 0 peaks in coarse bin 0 and pixel 1 in bin 15
    task automatic fillEdges();
        for (int i = 0; i < PASS_LEN; i++) begin
            case (pixelOf(i))
                0: begin
                    coarseStamps[i] = jitterAround(8, 7);
                    fineStamps[i]   = jitterAround(6, 2);
                end
                1: begin
                    coarseStamps[i] = jitterAround(247, 7);
                    fineStamps[i]   = jitterAround(238, 3);
                end
                default: begin
                    coarseStamps[i] = jitterAround(40 + 60 * pixelOf(i), 3);
                    fineStamps[i]   = jitterAround(40 + 60 * pixelOf(i), 3);
                end
            endcase
        end
    endtask

    // twelve of sixteen fine samples sit on one stamp outside the window
    task automatic fillOutOfWindow();
        int bin;
        int low;
        for (int i = 0; i < PASS_LEN; i++) begin
            bin = 3 + 3 * pixelOf(i);
            low = bin * COARSE_SPAN - histPkg::HALF_WIN;
            coarseStamps[i] = histPkg::STAMP_W'(bin * COARSE_SPAN + int'($urandom_range(15, 0)));
            if (sampleOf(i) < 3) fineStamps[i] = histPkg::STAMP_W'(low + 40);
            else fineStamps[i] = histPkg::STAMP_W'(low + 5 + acqOf(i) % 2);
        end
    endtask

    // two bins end level and the one fed early in each acquisition gets there first
    task automatic fillTies();
        int   binA;
        int   low;
        int   earlyOff;
        logic firstA;
        logic early;
        for (int i = 0; i < PASS_LEN; i++) begin
            binA     = 2 + 3 * pixelOf(i);
            firstA   = (pixelOf(i) % 2 == 0);
            early    = (sampleOf(i) < 2);
            low      = (firstA ? binA : binA + 1) * COARSE_SPAN - histPkg::HALF_WIN;
            earlyOff = firstA ? 11 : 3;
            coarseStamps[i] = histPkg::STAMP_W'(((early == firstA) ? binA : binA + 1) * COARSE_SPAN
                                                + int'($urandom_range(15, 0)));
            fineStamps[i] = histPkg::STAMP_W'(low + (early ? earlyOff : 14 - earlyOff));
        end
    endtask

    initial begin
        wrEn     = 1'b0;
        stamp    = '0;
        testName = "reset";
        void'($urandom(32'h6663));
        wait (combin_res === 1'b1);

        testName = "clustered";
        fillClustered();
        runCycle(0);
        testName = "edges";
        fillEdges();
        runCycle(0);
        testName = "outOfWindow";
        fillOutOfWindow();
        runCycle(0);
        testName = "ties";
        fillTies();
        runCycle(0);
        for (int c = 0; c < 3; c++) begin
            testName = $sformatf("repeated%0d", c);
            fillClustered();
            runCycle(MAX_GAP);
        end

        while (expQueue.size() != 0) @(posedge clk);
        repeat (IDLE_GAP) @(posedge clk); // room for a stray pulse
        if (resultCount == FINE_PASSES) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("error final: results expected %0d actual %0d", FINE_PASSES, resultCount);
            failAndStop();
        end
    end

    // one check per result pulse, half a cycle after it rises
    always @(negedge clk) begin
        if (combin_res && resultValid) begin
            assert (fineEnded > resultCount) else begin
                $display("resultValid pulsed although no fine pass had ended");
                failAndStop();
            end
            expVal  = expQueue.pop_front();
            expName = nameQueue.pop_front();
            assert (peakResults == expVal) else begin
                $display("error %s: expected %h actual %h", expName, expVal, peakResults);
                failAndStop();
            end
            resultCount = resultCount + 1;
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the run did not finish", cycleCount);
            failAndStop();
        end
    end

endmodule

//--- list.f
design/histPkg.sv
design/sampleTagIf.sv
design/acqSequencer.sv
design/binMapper.sv
design/histPeakTracker.sv
design/timingHistogrammer.sv
dv/clockGen.sv
dv/timingHistogrammerTb.sv
